// File: hdl/ssb_pkg.sv
`default_nettype none

package ssb_pkg;

    localparam int iq_dw          = 8;
    localparam int pss_len        = 16;
    localparam int num_nid2       = 3;
    localparam int nfft           = 8;
    localparam int cp_len         = 2;
    localparam int syms_after_pss = 3;
    localparam int sample_gap     = 8;     // min clocks between input samples
    localparam int pss_threshold  = 96;
    localparam int corr_dw        = 13;
    localparam int bin_dw         = 16;
    localparam int tw_dw          = 10;    // Q8 twiddles reach +-256
    localparam int tw_shift       = 8;
    localparam int acc_dw         = 22;

    // bit i applies to the i-th PSS sample in time order, 1 means -1
    localparam logic [pss_len-1:0] pss_seq [num_nid2] = '{16'h135E, 16'h6B3C, 16'h4A97};

    localparam int sc_first  = 1;
    localparam int sc_last   = 6;
    localparam int sss_first = 2;
    localparam int sss_last  = 5;

    typedef logic signed [iq_dw-1:0]   iq_t;
    typedef logic signed [corr_dw-1:0] corr_t;
    typedef logic [corr_dw:0]          metric_t;   // |re| + |im|
    typedef logic [1:0]                nid2_t;
    typedef logic [1:0]                sym_idx_t;  // 1..3 within the SSB
    typedef logic [$clog2(nfft)-1:0]   bin_idx_t;
    typedef logic signed [tw_dw-1:0]   tw_t;
    typedef logic signed [acc_dw-1:0]  acc_t;

    typedef struct packed {
        iq_t re;
        iq_t im;
    } sample_t;

    typedef struct packed {
        logic signed [bin_dw-1:0] re;
        logic signed [bin_dw-1:0] im;
    } bin_t;

    typedef struct packed {
        sample_t  sample;
        sym_idx_t sym;
        logic     last;
    } fs_stream_t;

    typedef struct packed {
        bin_t     bin;
        sym_idx_t sym;
        bin_idx_t idx;
    } dft_stream_t;

    typedef enum logic [1:0] {SEARCH, CP, BODY} fs_state_e;
    typedef enum logic [1:0] {IDLE, MAC, EMIT} dft_state_e;

endpackage

`default_nettype wire

// File: hdl/pss_correlator.sv
`timescale 1ns/10ps
`default_nettype none

module pss_correlator
    import ssb_pkg::*;
(
    input  wire          clk_i,
    input  wire          rst_n_i,
    input  wire sample_t sample_i,
    input  wire          sample_valid_i,
    input  wire          search_i,
    output sample_t      fwd_o,
    output logic         fwd_valid_o,
    output nid2_t        nid2_o,
    output logic         peak_o
);

    sample_t win [pss_len];         // win[0] is the oldest sample
    sample_t cur [pss_len];         // window including the incoming sample
    corr_t   corr_re [num_nid2];
    corr_t   corr_im [num_nid2];
    metric_t metric [num_nid2];
    logic [num_nid2-1:0] hit;
    logic    hit_any;
    nid2_t   hit_nid2;
    logic    detect;

    function automatic logic [corr_dw-1:0] mag(input corr_t v);
        return v[corr_dw-1] ? $unsigned(-v) : $unsigned(v);
    endfunction

    always_comb begin
        for (int i = 0; i < pss_len - 1; i++) begin
            cur[i] = win[i+1];
        end
        cur[pss_len-1] = sample_i;
    end

    // matched filter, signs only so no multipliers
    always_comb begin
        for (int s = 0; s < num_nid2; s++) begin
            corr_re[s] = '0;
            corr_im[s] = '0;
            for (int i = 0; i < pss_len; i++) begin
                if (pss_seq[s][i]) begin
                    corr_re[s] = corr_re[s] - corr_t'(cur[i].re);
                    corr_im[s] = corr_im[s] - corr_t'(cur[i].im);
                end else begin
                    corr_re[s] = corr_re[s] + corr_t'(cur[i].re);
                    corr_im[s] = corr_im[s] + corr_t'(cur[i].im);
                end
            end
            metric[s] = metric_t'(mag(corr_re[s])) + metric_t'(mag(corr_im[s]));
            hit[s] = metric[s] > metric_t'(pss_threshold);
        end
    end

    // lowest N_id_2 wins when several cross the threshold
    always_comb begin
        hit_nid2 = '0;
        for (int s = num_nid2 - 1; s >= 0; s--) begin
            if (hit[s]) begin
                hit_nid2 = nid2_t'(s);
            end
        end
    end

    assign hit_any = |hit;
    assign detect  = sample_valid_i && search_i && hit_any;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fwd_valid_o <= 1'b0;
            peak_o      <= 1'b0;
            win         <= '{default: '0};   // window starts empty
        end else begin
            fwd_valid_o <= sample_valid_i;
            peak_o      <= detect;
            if (sample_valid_i) begin
                win <= cur;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        fwd_o <= sample_i;
        if (detect) begin
            nid2_o <= hit_nid2;
        end
    end

endmodule

`default_nettype wire

// File: hdl/frame_sync.sv
`timescale 1ns/10ps
`default_nettype none

module frame_sync
    import ssb_pkg::*;
(
    input  wire          clk_i,
    input  wire          rst_n_i,
    input  wire          peak_i,
    input  wire sample_t sample_i,
    input  wire          sample_valid_i,
    output logic         search_o,
    output fs_stream_t   fs_o,
    output logic         fs_valid_o
);

    fs_state_e state;
    bin_idx_t  cnt;            // sample count within CP or body
    sym_idx_t  sym;
    logic      body_take;
    logic      body_end;

    assign search_o  = (state == SEARCH);
    assign body_take = (state == BODY) && sample_valid_i;
    assign body_end  = (cnt == nfft - 1);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state      <= SEARCH;
            cnt        <= '0;
            sym        <= '0;
            fs_valid_o <= 1'b0;
        end else begin
            fs_valid_o <= body_take;
            case (state)
                SEARCH: begin
                    // the peak arrives with the last PSS sample, which is dropped
                    if (peak_i) begin
                        state <= CP;
                        cnt   <= '0;
                        sym   <= sym_idx_t'(1);
                    end
                end
                CP: begin
                    if (sample_valid_i) begin
                        if (cnt == cp_len - 1) begin
                            state <= BODY;
                            cnt   <= '0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                BODY: begin
                    if (sample_valid_i) begin
                        cnt <= cnt + 1'b1;
                        if (body_end) begin
                            cnt <= '0;
                            if (sym == syms_after_pss) begin
                                state <= SEARCH;      // SSB done, re-arm
                            end else begin
                                sym   <= sym + 1'b1;
                                state <= CP;
                            end
                        end
                    end
                end
                default: state <= SEARCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (body_take) begin
            fs_o.sample <= sample_i;
            fs_o.sym    <= sym;
            fs_o.last   <= body_end;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dft_demod.sv
`timescale 1ns/10ps
`default_nettype none

module dft_demod
    import ssb_pkg::*;
(
    input  wire             clk_i,
    input  wire             rst_n_i,
    input  wire fs_stream_t fs_i,
    input  wire             fs_valid_i,
    output dft_stream_t     bin_o,
    output logic            bin_valid_o
);

    sample_t    bank [2][nfft];
    logic       wr_bank;
    logic       rd_bank;
    bin_idx_t   wr_ptr;
    dft_state_e state;
    bin_idx_t   k;                 // bin being computed
    bin_idx_t   n;                 // sample index within the bin sum
    sym_idx_t   cur_sym;
    logic       start;
    logic       bin_done;
    bin_idx_t   tw_idx;
    tw_t        tw_re;
    tw_t        tw_im;
    sample_t    x;
    acc_t       acc_re;
    acc_t       acc_im;
    acc_t       prod_re;
    acc_t       prod_im;
    acc_t       sum_re;
    acc_t       sum_im;
    acc_t       scaled_re;
    acc_t       scaled_im;

    assign start    = fs_valid_i && fs_i.last;
    assign bin_done = (state == MAC) && (n == nfft - 1);

    // input side fills one bank while the other is read
    always_ff @(posedge clk_i) begin
        if (fs_valid_i) begin
            bank[wr_bank][wr_ptr] <= fs_i.sample;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr  <= '0;
            wr_bank <= 1'b0;
        end else if (fs_valid_i) begin
            if (fs_i.last) begin
                wr_ptr  <= '0;
                wr_bank <= ~wr_bank;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    assign tw_idx = k * n;         // wraps mod 8 in 3 bits

    // e^(-j*2*pi*m/8) in Q8
    always_comb begin
        case (tw_idx)
            3'd0:    begin tw_re = tw_t'(256);  tw_im = tw_t'(0);    end
            3'd1:    begin tw_re = tw_t'(181);  tw_im = tw_t'(-181); end
            3'd2:    begin tw_re = tw_t'(0);    tw_im = tw_t'(-256); end
            3'd3:    begin tw_re = tw_t'(-181); tw_im = tw_t'(-181); end
            3'd4:    begin tw_re = tw_t'(-256); tw_im = tw_t'(0);    end
            3'd5:    begin tw_re = tw_t'(-181); tw_im = tw_t'(181);  end
            3'd6:    begin tw_re = tw_t'(0);    tw_im = tw_t'(256);  end
            default: begin tw_re = tw_t'(181);  tw_im = tw_t'(181);  end
        endcase
    end

    // the one complex multiplier, shared by all 64 terms
    assign x         = bank[rd_bank][n];
    assign prod_re   = x.re * tw_re - x.im * tw_im;
    assign prod_im   = x.re * tw_im + x.im * tw_re;
    assign sum_re    = acc_re + prod_re;
    assign sum_im    = acc_im + prod_im;
    assign scaled_re = sum_re >>> tw_shift;
    assign scaled_im = sum_im >>> tw_shift;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state       <= IDLE;
            k           <= '0;
            n           <= '0;
            bin_valid_o <= 1'b0;
        end else begin
            bin_valid_o <= bin_done;
            case (state)
                IDLE, EMIT: begin
                    if (start) begin
                        state <= MAC;
                        k     <= '0;
                        n     <= '0;
                    end else begin
                        state <= IDLE;
                    end
                end
                MAC: begin
                    n <= n + 1'b1;
                    if (bin_done) begin
                        k <= k + 1'b1;
                        if (k == nfft - 1) begin
                            state <= EMIT;   // last bin goes out, bank is free
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state != MAC && start) begin
            rd_bank <= wr_bank;
            cur_sym <= fs_i.sym;
            acc_re  <= '0;
            acc_im  <= '0;
        end else if (bin_done) begin
            acc_re           <= '0;
            acc_im           <= '0;
            bin_o.bin.re     <= scaled_re[bin_dw-1:0];
            bin_o.bin.im     <= scaled_im[bin_dw-1:0];
            bin_o.sym        <= cur_sym;
            bin_o.idx        <= k;
        end else if (state == MAC) begin
            acc_re <= sum_re;
            acc_im <= sum_im;
        end
    end

endmodule

`default_nettype wire

// File: hdl/bwp_extractor.sv
`timescale 1ns/10ps
`default_nettype none

module bwp_extractor
    import ssb_pkg::*;
(
    input  wire              clk_i,
    input  wire              rst_n_i,
    input  wire dft_stream_t bin_i,
    input  wire              bin_valid_i,
    output bin_t             data_o,
    output logic             data_valid_o,
    output logic             sss_valid_o,
    output logic             pbch_valid_o
);

    logic keep;
    logic is_sss;

    // DC and the edge bin carry nothing
    assign keep   = bin_valid_i && (bin_i.idx >= sc_first) && (bin_i.idx <= sc_last);
    assign is_sss = (bin_i.sym == sym_idx_t'(2))
                    && (bin_i.idx >= sss_first) && (bin_i.idx <= sss_last);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_valid_o <= 1'b0;
            sss_valid_o  <= 1'b0;
            pbch_valid_o <= 1'b0;
        end else begin
            data_valid_o <= keep;
            sss_valid_o  <= keep && is_sss;
            pbch_valid_o <= keep && !is_sss;
        end
    end

    always_ff @(posedge clk_i) begin
        if (keep) begin
            data_o <= bin_i.bin;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ssb_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module ssb_receiver
    import ssb_pkg::*;
(
    input  wire          clk_i,
    input  wire          rst_n_i,
    input  wire sample_t sample_i,
    input  wire          sample_valid_i,
    output nid2_t        nid2_o,
    output logic         peak_o,
    output bin_t         data_o,
    output logic         data_valid_o,
    output logic         sss_valid_o,
    output logic         pbch_valid_o
);

    sample_t     fwd;
    logic        fwd_valid;
    logic        search;
    fs_stream_t  fs;
    logic        fs_valid;
    dft_stream_t bin;
    logic        bin_valid;

    pss_correlator i_pss_correlator (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .search_i       (search),
        .fwd_o          (fwd),
        .fwd_valid_o    (fwd_valid),
        .nid2_o         (nid2_o),
        .peak_o         (peak_o)
    );

    frame_sync i_frame_sync (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .peak_i         (peak_o),
        .sample_i       (fwd),
        .sample_valid_i (fwd_valid),
        .search_o       (search),
        .fs_o           (fs),
        .fs_valid_o     (fs_valid)
    );

    dft_demod i_dft_demod (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .fs_i        (fs),
        .fs_valid_i  (fs_valid),
        .bin_o       (bin),
        .bin_valid_o (bin_valid)
    );

    bwp_extractor i_bwp_extractor (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .bin_i        (bin),
        .bin_valid_i  (bin_valid),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .sss_valid_o  (sss_valid_o),
        .pbch_valid_o (pbch_valid_o)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;    // 100 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/tb_ssb_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ssb_receiver
    import ssb_pkg::*;
();

    typedef struct packed {
        bin_t data;
        logic sss;
        logic pbch;
    } out_t;

    logic    clk;
    logic    rst_n;
    sample_t sample;
    logic    sample_valid;
    nid2_t   nid2;
    logic    peak;
    bin_t    data;
    logic    data_valid;
    logic    sss_valid;
    logic    pbch_valid;

    out_t    out_q [$];
    out_t    mon_entry;
    int      peak_count;
    nid2_t   last_nid2;

    tb_clock_gen i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ssb_receiver i_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .nid2_o         (nid2),
        .peak_o         (peak),
        .data_o         (data),
        .data_valid_o   (data_valid),
        .sss_valid_o    (sss_valid),
        .pbch_valid_o   (pbch_valid)
    );

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("FAIL %s: expected %0d, actual %0d", what, expected, actual);
            stop_run();
        end
    endtask

    // outputs are collected at the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (data_valid) begin
                mon_entry.data = data;
                mon_entry.sss  = sss_valid;
                mon_entry.pbch = pbch_valid;
                out_q.push_back(mon_entry);
            end
            assert (!(sss_valid && pbch_valid)) else begin
                $display("sss_valid_o and pbch_valid_o were high in the same cycle");
                stop_run();
            end
            if (peak) begin
                peak_count = peak_count + 1;
                last_nid2  = nid2;
            end
        end
    end

    task automatic send_sample(input int re, input int im);
        int gap;
        gap = int'($urandom_range(sample_gap + 4, sample_gap));
        @(negedge clk);
        sample.re    = iq_t'(re);
        sample.im    = iq_t'(im);
        sample_valid = 1'b1;
        @(negedge clk);
        sample_valid = 1'b0;
        repeat (gap - 1) @(negedge clk);
    endtask

    // noise stays well below the detection threshold
    task automatic send_noise(input int count);
        for (int i = 0; i < count; i++) begin
            send_sample(int'($urandom_range(6)) - 3, int'($urandom_range(6)) - 3);
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (!rst_n) begin
            @(negedge clk);
            cycles++;
            if (cycles > 50) begin
                $display("timeout: reset was never released");
                stop_run();
            end
        end
    endtask

    task automatic wait_peak(input int prev);
        int cycles;
        cycles = 0;
        while (peak_count == prev) begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) begin
                $display("timeout: no peak_o pulse after the PSS");
                stop_run();
            end
        end
    endtask

    task automatic wait_bins(input int count);
        int cycles;
        cycles = 0;
        while (out_q.size() < count) begin
            @(negedge clk);
            cycles++;
            if (cycles > 300) begin
                $display("timeout: only %0d of %0d kept bins arrived", out_q.size(), count);
                stop_run();
            end
        end
    endtask

    initial begin
        #5_000_000;
        $display("timeout: simulation time limit reached");
        stop_run();
    end

    initial begin
        int   fd;
        int   code;
        int   burst;
        int   sym;
        int   nid;
        int   re;
        int   im;
        int   peaks_before;
        int   exp_sss;
        int   in_re [10];
        int   in_im [10];
        int   exp_re [6];
        int   exp_im [6];
        logic [63:0]      tag;
        logic [8*256-1:0] rest;
        out_t got;
        string name;

        sample       = '0;
        sample_valid = 1'b0;
        peak_count   = 0;
        burst        = 0;
        void'($urandom(32'h2b52));

        fd = $fopen("test/ssb_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open test/ssb_stim.txt");
            stop_run();
        end

        wait_reset();
        send_noise(220);
        check_value("no detection in leading noise", 0, peak_count);

        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "P") begin
                code = $fscanf(fd, "%d", nid);
                if (burst > 0) begin
                    send_noise(40);
                    check_value("no bins between bursts", 0, out_q.size());
                    check_value("no detection between bursts", burst, peak_count);
                end
                burst++;
                for (int i = 0; i < 16; i++) begin
                    send_sample(0, 0);    // quiet lead-in clears the window
                end
                peaks_before = peak_count;
                for (int i = 0; i < pss_len; i++) begin
                    code = $fscanf(fd, "%d %d", re, im);
                    send_sample(re, im);
                end
                wait_peak(peaks_before);
                name = $sformatf("burst %0d", burst);
                check_value({name, " peak count"}, burst, peak_count);
                check_value({name, " nid2"}, nid, int'(last_nid2));
            end else if (tag == "S") begin
                for (int i = 0; i < 10; i++) begin
                    code = $fscanf(fd, "%d %d", in_re[i], in_im[i]);
                end
                for (int i = 0; i < 6; i++) begin
                    code = $fscanf(fd, "%d %d", exp_re[i], exp_im[i]);
                end
                code = $fscanf(fd, "%d", sym);
                name = $sformatf("burst %0d sym %0d", burst, sym);
                check_value({name, " queue empty"}, 0, out_q.size());
                for (int i = 0; i < 10; i++) begin
                    send_sample(in_re[i], in_im[i]);
                end
                wait_bins(6);
                repeat (30) @(negedge clk);   // bin 7 must be dropped
                check_value({name, " bin count"}, 6, out_q.size());
                for (int b = 0; b < 6; b++) begin
                    got     = out_q.pop_front();
                    name    = $sformatf("burst %0d sym %0d bin %0d", burst, sym, b + 1);
                    exp_sss = (sym == 2 && b + 1 >= sss_first && b + 1 <= sss_last) ? 1 : 0;
                    check_value({name, " re"}, exp_re[b], int'($signed(got.data.re)));
                    check_value({name, " im"}, exp_im[b], int'($signed(got.data.im)));
                    check_value({name, " sss flag"}, exp_sss, int'(got.sss));
                    check_value({name, " pbch flag"}, 1 - exp_sss, int'(got.pbch));
                end
            end else begin
                $display("unknown line type in test/ssb_stim.txt");
                stop_run();
            end
        end
        $fclose(fd);

        send_noise(40);
        check_value("no bins after last burst", 0, out_q.size());
        check_value("total detections", burst, peak_count);
        check_value("bursts in stim file", 3, burst);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hdl/ssb_pkg.sv
hdl/pss_correlator.sv
hdl/frame_sync.sv
hdl/dft_demod.sv
hdl/bwp_extractor.sv
hdl/ssb_receiver.sv
test/tb_clock_gen.sv
test/tb_ssb_receiver.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ssb_receiver -f sources.f \
    && ./obj_dir/Vtb_ssb_receiver 2>&1 | tee /dev/stderr | grep -q -F "Simulation passed" \
    && echo "run_sim.sh: pass line found" \
    || { echo "run_sim.sh: build error or no pass line"; exit 1; }

// File: test/ssb_stim.txt
# P nid2, then 16 re im pairs of the PSS
# S 10 re im input pairs (2 CP, 8 body), 6 expected re im for bins 1..6, symbol index

# burst 1
P 0 7 0 -7 0 -7 0 -7 0 -7 0 7 0 -7 0 7 0 -7 0 -7 0 7 0 7 0 -7 0 7 0 7 0 7 0
S 20 -20 20 -20 0 0 16 0 0 0 0 0 0 0 0 0 0 0 0 0 11 -12 0 -16 -12 -12 -16 0 -12 11 0 16 1
S 0 0 0 0 0 0 0 0 16 0 0 0 0 0 0 0 0 0 0 0 0 -16 -16 0 0 16 16 0 0 -16 -16 0 2
S 3 3 3 3 10 -5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10 -5 10 -5 10 -5 10 -5 10 -5 10 -5 3

# burst 2
P 1 7 0 7 0 -7 0 -7 0 -7 0 -7 0 7 0 7 0 -7 0 -7 0 7 0 -7 0 7 0 -7 0 -7 0 7 0
S -20 20 -20 20 0 0 0 16 0 0 0 0 0 0 0 0 0 0 0 0 11 11 16 0 11 -12 0 -16 -12 -12 -16 0 1
S 0 0 0 0 0 0 0 0 0 0 0 0 -8 0 0 0 0 0 0 0 8 0 -8 0 8 0 -8 0 8 0 -8 0 2
S 2 -2 2 -2 -7 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -7 4 -7 4 -7 4 -7 4 -7 4 -7 4 3

# burst 3
P 2 -7 0 -7 0 -7 0 7 0 -7 0 7 0 7 0 -7 0 7 0 -7 0 7 0 -7 0 7 0 7 0 -7 0 7 0
S 20 -20 20 -20 0 0 16 0 0 0 0 0 0 0 0 0 0 0 0 0 11 -12 0 -16 -12 -12 -16 0 -12 11 0 16 1
S 0 0 0 0 0 0 0 0 16 0 0 0 0 0 0 0 0 0 0 0 0 -16 -16 0 0 16 16 0 0 -16 -16 0 2
S 3 3 3 3 10 -5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10 -5 10 -5 10 -5 10 -5 10 -5 10 -5 3
